//--- hdl/idli_pkg.sv
// Shared widths, register names and encodings for the nibble-serial
// execute stage. Everything here is taken by scoped name.
package idli_pkg;

  // Each instruction works on one slice per cycle over four cycles.
  localparam int SLICE_W  = 4;
  localparam int DATA_W   = 16;
  localparam int NUM_PINS = 4;
  localparam int NUM_REGS = 16;

  // Sync counter owned by the outside system.
  typedef logic [1:0] ctr_t;

  // Data slice, full register and full encoding.
  typedef logic [SLICE_W-1:0] slice_t;
  typedef logic [DATA_W-1:0]  data_t;

  // Register index, conditional-execution window and pin types.
  typedef logic [3:0]          reg_t;
  typedef logic [7:0]          cond_t;
  typedef logic [NUM_PINS-1:0] io_pins_t;
  typedef logic [1:0]          pin_idx_t;

  // Register zero always reads as zero.
  localparam reg_t REG_ZR = reg_t'(0);

  // Opcodes held in the top nibble of the encoding.
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_LDI  = 4'h4,
    OP_EQ   = 4'h5,
    OP_NE   = 4'h6,
    OP_LT   = 4'h7,
    OP_LTU  = 4'h8,
    OP_GE   = 4'h9,
    OP_GEU  = 4'ha,
    OP_COND = 4'hb,
    OP_IN   = 4'hc,
    OP_OUT  = 4'hd,
    OP_OUTN = 4'he,
    OP_OUTP = 4'hf
  } op_t;

  // ALU operations. PASS forwards the right operand unchanged.
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_AND,
    ALU_OR,
    ALU_PASS
  } alu_op_t;

  // Comparisons that write the predicate register.
  typedef enum logic [2:0] {
    CMP_EQ,
    CMP_NE,
    CMP_LT,
    CMP_LTU,
    CMP_GE,
    CMP_GEU
  } cmp_op_t;

  // Pin unit operations.
  typedef enum logic [1:0] {
    PIN_IN,
    PIN_OUT,
    PIN_OUTN,
    PIN_OUTP
  } pin_op_t;

endpackage

//--- hdl/idli_alu_m.sv
`timescale 1ns/100ps

// Slice ALU. The carry ripples between slices through a flop, and the
// flags describe the whole 16-bit result once the final slice is present.
module idli_alu_m (
  input  var logic                i_alu_gck,

  input  var idli_pkg::ctr_t      i_alu_ctr,
  input  var idli_pkg::alu_op_t   i_alu_op,
  input  var logic                i_alu_sub,

  input  var idli_pkg::slice_t    i_alu_lhs,
  input  var idli_pkg::slice_t    i_alu_rhs,
  output var idli_pkg::slice_t    o_alu_out,

  output var logic                o_alu_flag_z,
  output var logic                o_alu_flag_n,
  output var logic                o_alu_flag_c,
  output var logic                o_alu_flag_v
);

  idli_pkg::slice_t             rhs;
  logic                         cin;
  logic [idli_pkg::SLICE_W:0]   sum;
  logic                         carry_q;
  logic                         zero_q;
  logic                         first;

  always_comb first = i_alu_ctr == '0;

  // Subtraction is the sum with the right operand inverted and a carry in
  // of one on the first slice.
  always_comb rhs = i_alu_sub ? ~i_alu_rhs : i_alu_rhs;
  always_comb cin = first ? i_alu_sub : carry_q;

  always_comb sum = {1'b0, i_alu_lhs} + {1'b0, rhs} + {{idli_pkg::SLICE_W{1'b0}}, cin};

  always_comb begin
    case (i_alu_op)
      idli_pkg::ALU_ADD: o_alu_out = sum[idli_pkg::SLICE_W-1:0];
      idli_pkg::ALU_AND: o_alu_out = i_alu_lhs & i_alu_rhs;
      idli_pkg::ALU_OR:  o_alu_out = i_alu_lhs | i_alu_rhs;
      default:           o_alu_out = i_alu_rhs;
    endcase
  end

  // Carry out of this slice feeds the next. Zero is tracked across slices
  // and restarts on the first slice of each instruction.
  always_ff @(posedge i_alu_gck) begin
    carry_q <= sum[idli_pkg::SLICE_W];
    zero_q  <= (first || zero_q) && o_alu_out == '0;
  end

  // These are only meaningful at counter 3, when the top slice is here.
  always_comb o_alu_flag_z = (first || zero_q) && o_alu_out == '0;
  always_comb o_alu_flag_n = o_alu_out[idli_pkg::SLICE_W-1];
  always_comb o_alu_flag_c = sum[idli_pkg::SLICE_W];

  // Overflow when both inputs share a sign that the result does not.
  always_comb o_alu_flag_v = i_alu_lhs[idli_pkg::SLICE_W-1] == rhs[idli_pkg::SLICE_W-1]
                          && sum[idli_pkg::SLICE_W-1] != i_alu_lhs[idli_pkg::SLICE_W-1];

endmodule

//--- hdl/idli_cond_m.sv
`timescale 1ns/100ps

// Predicate register and conditional-execution window. Both change only at
// the counter-3 edge, so skip is steady for a whole instruction.
module idli_cond_m (
  input  var logic                i_cd_gck,
  input  var logic                i_cd_rst_n,

  input  var idli_pkg::ctr_t      i_cd_ctr,
  input  var logic                i_cd_vld,
  input  var idli_pkg::cmp_op_t   i_cd_cmp_op,
  input  var logic                i_cd_cmp_wr,
  input  var logic                i_cd_cond_wr,
  input  var idli_pkg::cond_t     i_cd_cond,

  input  var logic                i_cd_flag_z,
  input  var logic                i_cd_flag_n,
  input  var logic                i_cd_flag_c,
  input  var logic                i_cd_flag_v,

  output var logic                o_cd_pred,
  output var logic                o_cd_skip
);

  logic            pred_q;
  logic            pred_d;
  idli_pkg::cond_t window_q;

  // Bit 0 says which value of P the next instruction runs on. The window
  // is only live while some higher bit is still set.
  always_comb o_cd_skip = |window_q[7:1] && pred_q != window_q[0];
  always_comb o_cd_pred = pred_q;

  // Comparison result from the flags of the final slice.
  always_comb begin
    case (i_cd_cmp_op)
      idli_pkg::CMP_NE:  pred_d = !i_cd_flag_z;
      idli_pkg::CMP_LT:  pred_d = i_cd_flag_n != i_cd_flag_v;
      idli_pkg::CMP_GE:  pred_d = i_cd_flag_n == i_cd_flag_v;
      idli_pkg::CMP_LTU: pred_d = !i_cd_flag_c;
      idli_pkg::CMP_GEU: pred_d = i_cd_flag_c;
      default:           pred_d = i_cd_flag_z;
    endcase
  end

  always_ff @(posedge i_cd_gck, negedge i_cd_rst_n) begin
    if (!i_cd_rst_n) begin
      pred_q <= '0;
    end else if (&i_cd_ctr && i_cd_cmp_wr) begin
      pred_q <= pred_d;
    end
  end

  // An executed COND loads a new window. Every other valid instruction,
  // including a skipped one, moves the window on by one.
  always_ff @(posedge i_cd_gck, negedge i_cd_rst_n) begin
    if (!i_cd_rst_n) begin
      window_q <= '0;
    end else if (&i_cd_ctr && i_cd_vld) begin
      if (i_cd_cond_wr) begin
        window_q <= i_cd_cond;
      end else begin
        window_q <= {1'b0, window_q[7:1]};
      end
    end
  end

endmodule

//--- hdl/idli_decode_m.sv
`timescale 1ns/100ps

// Instruction decoder. The encoding is captured at the counter-3 edge and
// held for the four cycles of its execution.
module idli_decode_m (
  input  var logic                i_de_gck,
  input  var logic                i_de_rst_n,

  input  var idli_pkg::ctr_t      i_de_ctr,
  input  var idli_pkg::data_t     i_de_enc,
  input  var logic                i_de_enc_vld,
  input  var logic                i_de_skip,

  output var logic                o_de_vld,
  output var idli_pkg::reg_t      o_de_lhs_reg,
  output var idli_pkg::reg_t      o_de_rhs_reg,
  output var idli_pkg::reg_t      o_de_dst_reg,
  output var logic                o_de_dst_wr,
  output var idli_pkg::alu_op_t   o_de_alu_op,
  output var logic                o_de_sub,
  output var idli_pkg::slice_t    o_de_imm,
  output var idli_pkg::cmp_op_t   o_de_cmp_op,
  output var logic                o_de_cmp_wr,
  output var logic                o_de_cond_wr,
  output var idli_pkg::cond_t     o_de_cond,
  output var idli_pkg::pin_op_t   o_de_pin_op,
  output var idli_pkg::pin_idx_t  o_de_pin_idx,
  output var logic                o_de_pin_run
);

  // Held encoding and whether it is a real instruction or a bubble.
  idli_pkg::data_t enc_q;
  logic            vld_q;
  idli_pkg::op_t   op;

  // Raw write requests before valid and skip are applied.
  logic dst_wr_raw;
  logic cmp_wr_raw;
  logic cond_wr_raw;
  logic pin_raw;
  logic ldi;
  logic run;

  // Valid level of the held encoding, low after reset.
  always_ff @(posedge i_de_gck, negedge i_de_rst_n) begin
    if (!i_de_rst_n) begin
      vld_q <= '0;
    end else if (&i_de_ctr) begin
      vld_q <= i_de_enc_vld;
    end
  end

  always_ff @(posedge i_de_gck) begin
    if (&i_de_ctr && i_de_enc_vld) begin
      enc_q <= i_de_enc;
    end
  end

  always_comb op = idli_pkg::op_t'(enc_q[15:12]);

  // Map the opcode to unit controls. Comparisons run as a subtraction and
  // only keep the flags.
  always_comb begin
    o_de_alu_op = idli_pkg::ALU_PASS;
    o_de_sub    = '0;
    o_de_cmp_op = idli_pkg::CMP_EQ;
    o_de_pin_op = idli_pkg::PIN_IN;
    dst_wr_raw  = '0;
    cmp_wr_raw  = '0;
    cond_wr_raw = '0;
    pin_raw     = '0;
    ldi         = '0;

    case (op)
      idli_pkg::OP_ADD: begin
        o_de_alu_op = idli_pkg::ALU_ADD;
        dst_wr_raw  = '1;
      end
      idli_pkg::OP_SUB: begin
        o_de_alu_op = idli_pkg::ALU_ADD;
        o_de_sub    = '1;
        dst_wr_raw  = '1;
      end
      idli_pkg::OP_AND: begin
        o_de_alu_op = idli_pkg::ALU_AND;
        dst_wr_raw  = '1;
      end
      idli_pkg::OP_OR: begin
        o_de_alu_op = idli_pkg::ALU_OR;
        dst_wr_raw  = '1;
      end
      idli_pkg::OP_LDI: begin
        ldi        = '1;
        dst_wr_raw = '1;
      end
      idli_pkg::OP_COND: cond_wr_raw = '1;
      idli_pkg::OP_IN: begin
        pin_raw    = '1;
        dst_wr_raw = '1;
      end
      idli_pkg::OP_OUT: begin
        pin_raw     = '1;
        o_de_pin_op = idli_pkg::PIN_OUT;
      end
      idli_pkg::OP_OUTN: begin
        pin_raw     = '1;
        o_de_pin_op = idli_pkg::PIN_OUTN;
      end
      idli_pkg::OP_OUTP: begin
        pin_raw     = '1;
        o_de_pin_op = idli_pkg::PIN_OUTP;
      end
      default: begin
        // The remaining opcodes are the six comparisons.
        o_de_alu_op = idli_pkg::ALU_ADD;
        o_de_sub    = '1;
        cmp_wr_raw  = '1;
        case (op)
          idli_pkg::OP_NE:  o_de_cmp_op = idli_pkg::CMP_NE;
          idli_pkg::OP_LT:  o_de_cmp_op = idli_pkg::CMP_LT;
          idli_pkg::OP_LTU: o_de_cmp_op = idli_pkg::CMP_LTU;
          idli_pkg::OP_GE:  o_de_cmp_op = idli_pkg::CMP_GE;
          idli_pkg::OP_GEU: o_de_cmp_op = idli_pkg::CMP_GEU;
          default:          o_de_cmp_op = idli_pkg::CMP_EQ;
        endcase
      end
    endcase
  end

  // Register fields. LDI reads REG_ZR on the right so the immediate is the
  // only thing that reaches the ALU.
  always_comb o_de_dst_reg = enc_q[11:8];
  always_comb o_de_lhs_reg = enc_q[7:4];
  always_comb o_de_rhs_reg = ldi ? idli_pkg::REG_ZR : enc_q[3:0];

  // The 8-bit immediate covers slices 0 and 1. Higher slices are zero.
  always_comb begin
    o_de_imm = '0;
    if (ldi) begin
      case (i_de_ctr)
        2'd0:    o_de_imm = enc_q[3:0];
        2'd1:    o_de_imm = enc_q[7:4];
        default: o_de_imm = '0;
      endcase
    end
  end

  always_comb o_de_cond    = enc_q[7:0];
  always_comb o_de_pin_idx = enc_q[1:0];

  // Nothing writes architectural state unless it is valid and not skipped.
  always_comb run          = vld_q && !i_de_skip;
  always_comb o_de_vld     = vld_q;
  always_comb o_de_dst_wr  = run && dst_wr_raw;
  always_comb o_de_cmp_wr  = run && cmp_wr_raw;
  always_comb o_de_cond_wr = run && cond_wr_raw;
  always_comb o_de_pin_run = run && pin_raw;

endmodule

//--- hdl/idli_pins_m.sv
`timescale 1ns/100ps

// Pin unit. Inputs are sampled every cycle; outputs change at the
// counter-0 edge of an executed OUT, OUTN or OUTP.
module idli_pins_m (
  input  var logic                i_pn_gck,
  input  var logic                i_pn_rst_n,

  input  var idli_pkg::ctr_t      i_pn_ctr,
  input  var logic                i_pn_run,
  input  var idli_pkg::pin_op_t   i_pn_op,
  input  var idli_pkg::pin_idx_t  i_pn_idx,
  input  var idli_pkg::slice_t    i_pn_lhs,
  input  var logic                i_pn_pred,
  input  var idli_pkg::io_pins_t  i_pn_pins,

  output var idli_pkg::slice_t    o_pn_data,
  output var idli_pkg::io_pins_t  o_pn_pins
);

  idli_pkg::io_pins_t in_pins_q;
  idli_pkg::io_pins_t out_pins_q;
  logic               out_bit;

  always_ff @(posedge i_pn_gck) begin
    in_pins_q <= i_pn_pins;
  end

  // IN gives the selected pin as bit 0 of the first slice, zero above.
  always_comb begin
    o_pn_data = '0;
    if (i_pn_ctr == '0) begin
      o_pn_data[0] = in_pins_q[i_pn_idx];
    end
  end

  // Bit to drive, from the left register or from P.
  always_comb begin
    case (i_pn_op)
      idli_pkg::PIN_OUT:  out_bit = i_pn_lhs[0];
      idli_pkg::PIN_OUTN: out_bit = !i_pn_lhs[0];
      default:            out_bit = i_pn_pred;
    endcase
  end

  // Only the selected pin changes; the others keep their level.
  always_ff @(posedge i_pn_gck, negedge i_pn_rst_n) begin
    if (!i_pn_rst_n) begin
      out_pins_q <= '0;
    end else if (i_pn_run && i_pn_ctr == '0 && i_pn_op != idli_pkg::PIN_IN) begin
      out_pins_q[i_pn_idx] <= out_bit;
    end
  end

  always_comb o_pn_pins = out_pins_q;

endmodule

//--- hdl/idli_rf_m.sv
`timescale 1ns/100ps

// Nibble-serial register file. Every register rotates right by one slice
// each cycle, so the low slice is always the one for the current counter.
module idli_rf_m (
  input  var logic              i_rf_gck,

  input  var idli_pkg::reg_t    i_rf_lhs,
  input  var idli_pkg::reg_t    i_rf_rhs,
  input  var idli_pkg::reg_t    i_rf_dst,
  input  var logic              i_rf_dst_en,
  input  var idli_pkg::slice_t  i_rf_dst_data,

  output var idli_pkg::slice_t  o_rf_lhs_data,
  output var idli_pkg::slice_t  o_rf_rhs_data
);

  idli_pkg::data_t regs_q [idli_pkg::NUM_REGS];

  // Return the current slice of a register, with REG_ZR forced to zero.
  function automatic idli_pkg::slice_t read_slice(idli_pkg::reg_t idx);
    idli_pkg::slice_t val;
    val = regs_q[idx][idli_pkg::SLICE_W-1:0];
    if (idx == idli_pkg::REG_ZR) begin
      val = '0;
    end
    return val;
  endfunction

  // The outgoing low slice comes back in at the top, or the new write data
  // replaces it. After four cycles the register is aligned again.
  always_ff @(posedge i_rf_gck) begin
    for (int i = 0; i < idli_pkg::NUM_REGS; i++) begin
      if (i_rf_dst_en && i_rf_dst == idli_pkg::reg_t'(i)) begin
        regs_q[i] <= {i_rf_dst_data,
                      regs_q[i][idli_pkg::DATA_W-1:idli_pkg::SLICE_W]};
      end else begin
        regs_q[i] <= {regs_q[i][idli_pkg::SLICE_W-1:0],
                      regs_q[i][idli_pkg::DATA_W-1:idli_pkg::SLICE_W]};
      end
    end
  end

  always_comb o_rf_lhs_data = read_slice(i_rf_lhs);
  always_comb o_rf_rhs_data = read_slice(i_rf_rhs);

endmodule

//--- hdl/idli_ex_m.sv
`timescale 1ns/100ps

// Execute stage top level. An encoding accepted at counter 3 runs over the
// next four cycles, one slice per cycle, least significant slice first.
module idli_ex_m (
  // Clock and reset.
  input  var logic                i_ex_gck,
  input  var logic                i_ex_rst_n,

  // Sync counter and the encoding presented for the next instruction.
  input  var idli_pkg::ctr_t      i_ex_ctr,
  input  var idli_pkg::data_t     i_ex_enc,
  input  var logic                i_ex_enc_vld,

  // Register write stream.
  output var idli_pkg::slice_t    o_ex_data,
  output var logic                o_ex_wr,
  output var idli_pkg::reg_t      o_ex_wr_reg,

  // IO pins.
  input  var idli_pkg::io_pins_t  i_ex_io_pins,
  output var idli_pkg::io_pins_t  o_ex_io_pins
);

  // Decoded control for the instruction in flight.
  logic                 vld;
  idli_pkg::reg_t       lhs_reg;
  idli_pkg::reg_t       rhs_reg;
  idli_pkg::reg_t       dst_reg;
  logic                 dst_wr;
  idli_pkg::alu_op_t    alu_op;
  logic                 sub;
  idli_pkg::slice_t     imm;
  idli_pkg::cmp_op_t    cmp_op;
  logic                 cmp_wr;
  logic                 cond_wr;
  idli_pkg::cond_t      cond;
  idli_pkg::pin_op_t    pin_op;
  idli_pkg::pin_idx_t   pin_idx;
  logic                 pin_run;

  // Operand slices from the register file and the ALU right operand.
  idli_pkg::slice_t lhs_data;
  idli_pkg::slice_t rhs_data;
  idli_pkg::slice_t alu_rhs;

  // ALU result and flags.
  idli_pkg::slice_t alu_out;
  logic             alu_z;
  logic             alu_n;
  logic             alu_c;
  logic             alu_v;

  // Condition state and pin data.
  logic             pred;
  logic             skip;
  idli_pkg::slice_t pin_data;
  idli_pkg::slice_t wr_data;

  // Decoder holds the encoding and gates all writes with valid and not-skip.
  idli_decode_m decode_u (
    .i_de_gck     (i_ex_gck),
    .i_de_rst_n   (i_ex_rst_n),
    .i_de_ctr     (i_ex_ctr),
    .i_de_enc     (i_ex_enc),
    .i_de_enc_vld (i_ex_enc_vld),
    .i_de_skip    (skip),
    .o_de_vld     (vld),
    .o_de_lhs_reg (lhs_reg),
    .o_de_rhs_reg (rhs_reg),
    .o_de_dst_reg (dst_reg),
    .o_de_dst_wr  (dst_wr),
    .o_de_alu_op  (alu_op),
    .o_de_sub     (sub),
    .o_de_imm     (imm),
    .o_de_cmp_op  (cmp_op),
    .o_de_cmp_wr  (cmp_wr),
    .o_de_cond_wr (cond_wr),
    .o_de_cond    (cond),
    .o_de_pin_op  (pin_op),
    .o_de_pin_idx (pin_idx),
    .o_de_pin_run (pin_run)
  );

  // Register file, read and written one slice per cycle.
  idli_rf_m rf_u (
    .i_rf_gck      (i_ex_gck),
    .i_rf_lhs      (lhs_reg),
    .i_rf_rhs      (rhs_reg),
    .i_rf_dst      (dst_reg),
    .i_rf_dst_en   (dst_wr),
    .i_rf_dst_data (wr_data),
    .o_rf_lhs_data (lhs_data),
    .o_rf_rhs_data (rhs_data)
  );

  // For LDI the decoder points the right register at REG_ZR, which reads
  // zero, so the immediate can simply be merged in. Other ops give a zero
  // immediate and leave the register data untouched.
  always_comb alu_rhs = rhs_data | imm;

  idli_alu_m alu_u (
    .i_alu_gck    (i_ex_gck),
    .i_alu_ctr    (i_ex_ctr),
    .i_alu_op     (alu_op),
    .i_alu_sub    (sub),
    .i_alu_lhs    (lhs_data),
    .i_alu_rhs    (alu_rhs),
    .o_alu_out    (alu_out),
    .o_alu_flag_z (alu_z),
    .o_alu_flag_n (alu_n),
    .o_alu_flag_c (alu_c),
    .o_alu_flag_v (alu_v)
  );

  // Predicate and conditional-execution window.
  idli_cond_m cond_u (
    .i_cd_gck     (i_ex_gck),
    .i_cd_rst_n   (i_ex_rst_n),
    .i_cd_ctr     (i_ex_ctr),
    .i_cd_vld     (vld),
    .i_cd_cmp_op  (cmp_op),
    .i_cd_cmp_wr  (cmp_wr),
    .i_cd_cond_wr (cond_wr),
    .i_cd_cond    (cond),
    .i_cd_flag_z  (alu_z),
    .i_cd_flag_n  (alu_n),
    .i_cd_flag_c  (alu_c),
    .i_cd_flag_v  (alu_v),
    .o_cd_pred    (pred),
    .o_cd_skip    (skip)
  );

  // Pin unit. Output pins take the left register's bit 0 or P.
  idli_pins_m pins_u (
    .i_pn_gck   (i_ex_gck),
    .i_pn_rst_n (i_ex_rst_n),
    .i_pn_ctr   (i_ex_ctr),
    .i_pn_run   (pin_run),
    .i_pn_op    (pin_op),
    .i_pn_idx   (pin_idx),
    .i_pn_lhs   (lhs_data),
    .i_pn_pred  (pred),
    .i_pn_pins  (i_ex_io_pins),
    .o_pn_data  (pin_data),
    .o_pn_pins  (o_ex_io_pins)
  );

  // IN writes the sampled pin, every other register write takes the ALU.
  always_comb begin
    wr_data = alu_out;
    if (pin_run && pin_op == idli_pkg::PIN_IN) begin
      wr_data = pin_data;
    end
  end

  // The write stream mirrors what goes into the register file.
  always_comb o_ex_data   = wr_data;
  always_comb o_ex_wr     = dst_wr;
  always_comb o_ex_wr_reg = dst_reg;

endmodule

//--- dv/idli_clk_gen.sv
`timescale 1ns/100ps

// Clock and reset source for the testbench. The clock has a 100 ns period
// and reset is held low over the first three rising edges.
module idli_clk_gen (
  output var logic o_gck,
  output var logic o_rst_n
);

  initial begin
    o_gck = 1'b0;
    forever #50 o_gck = ~o_gck;
  end

  // Reset goes high on the falling edge after the third rising edge.
  initial begin
    o_rst_n = 1'b0;
    repeat (3) @(posedge o_gck);
    @(negedge o_gck);
    o_rst_n = 1'b1;
  end

endmodule

//--- dv/idli_ex_props.sv
`timescale 1ns/100ps

// Port timing rules of the execute stage, sampled on every rising edge.
module idli_ex_props (
  input var logic                i_gck,
  input var logic                i_rst_n,
  input var idli_pkg::ctr_t      i_ctr,
  input var logic                i_wr,
  input var idli_pkg::reg_t      i_wr_reg,
  input var idli_pkg::io_pins_t  i_pins
);

  // The write strobe is one level for all four slices of an instruction.
  wr_steady_a : assert property (
    @(posedge i_gck) disable iff (!i_rst_n)
    i_ctr != 2'd3 |=> $stable(i_wr)
  ) else $error("o_ex_wr changed in the middle of an instruction");

  // The destination is held for as long as the write is shown.
  wr_reg_steady_a : assert property (
    @(posedge i_gck) disable iff (!i_rst_n)
    (i_ctr != 2'd3 && i_wr) |=> $stable(i_wr_reg)
  ) else $error("o_ex_wr_reg changed in the middle of a register write");

  // Output pins move only on the edge that ends counter 0.
  pins_edge_a : assert property (
    @(posedge i_gck) disable iff (!i_rst_n)
    i_ctr != 2'd0 |=> $stable(i_pins)
  ) else $error("o_ex_io_pins changed away from the counter-0 edge");

  // Nothing may be written while reset is held.
  wr_reset_a : assert property (
    @(posedge i_gck)
    !i_rst_n |-> !i_wr
  ) else $error("o_ex_wr was high during reset");

endmodule

bind idli_ex_m idli_ex_props props_u (
  .i_gck    (i_ex_gck),
  .i_rst_n  (i_ex_rst_n),
  .i_ctr    (i_ex_ctr),
  .i_wr     (o_ex_wr),
  .i_wr_reg (o_ex_wr_reg),
  .i_pins   (o_ex_io_pins)
);

//--- dv/idli_tb.sv
`timescale 1ns/100ps

// Testbench for the execute stage. A program is built up front, presented
// one encoding per four cycles, and every instruction in flight is checked
// against a reference model of registers, P, the window and the pins.
module idli_tb;

  logic                gck;
  logic                rst_n;

  idli_pkg::ctr_t      ex_ctr;
  idli_pkg::data_t     ex_enc;
  logic                ex_enc_vld;
  idli_pkg::io_pins_t  ex_pins_in;
  idli_pkg::slice_t    ex_data;
  logic                ex_wr;
  idli_pkg::reg_t      ex_wr_reg;
  idli_pkg::io_pins_t  ex_pins_out;

  // Program entries, each with the input pin level driven beside it.
  idli_pkg::data_t     prog_enc [$];
  logic                prog_vld [$];
  idli_pkg::io_pins_t  prog_pins [$];

  // Reference model state.
  idli_pkg::data_t     model_regs [16];
  logic                model_pred;
  idli_pkg::cond_t     model_win;
  idli_pkg::io_pins_t  model_pins;

  // What the instruction in flight must show, and the slices seen so far.
  logic                exp_wr;
  idli_pkg::reg_t      exp_reg;
  idli_pkg::data_t     exp_data;
  idli_pkg::io_pins_t  exp_pins_before;
  idli_pkg::io_pins_t  exp_pins_after;
  idli_pkg::data_t     got_data;

  int checks;
  int errors;
  int limit;
  int cycles = 0;

  idli_clk_gen clk_u (
    .o_gck   (gck),
    .o_rst_n (rst_n)
  );

  idli_ex_m uut (
    .i_ex_gck     (gck),
    .i_ex_rst_n   (rst_n),
    .i_ex_ctr     (ex_ctr),
    .i_ex_enc     (ex_enc),
    .i_ex_enc_vld (ex_enc_vld),
    .o_ex_data    (ex_data),
    .o_ex_wr      (ex_wr),
    .o_ex_wr_reg  (ex_wr_reg),
    .i_ex_io_pins (ex_pins_in),
    .o_ex_io_pins (ex_pins_out)
  );

  // Nibbles from the top are opcode, destination, left and right.
  function automatic idli_pkg::data_t make_enc(input idli_pkg::op_t op,
      input idli_pkg::reg_t dst, input idli_pkg::reg_t lhs, input idli_pkg::reg_t rhs);
    return {op, dst, lhs, rhs};
  endfunction

  function automatic idli_pkg::data_t random_enc();
    return idli_pkg::data_t'($urandom_range(16'hffff, 0));
  endfunction

  task automatic push_instr(input idli_pkg::data_t enc);
    prog_enc.push_back(enc);
    prog_vld.push_back(1'b1);
    prog_pins.push_back(idli_pkg::io_pins_t'($urandom_range(15, 0)));
  endtask

  // A bubble still carries a random encoding, which must be ignored.
  task automatic push_bubble();
    prog_enc.push_back(random_enc());
    prog_vld.push_back(1'b0);
    prog_pins.push_back(idli_pkg::io_pins_t'($urandom_range(15, 0)));
  endtask

  task automatic build_program();
    idli_pkg::op_t alu_list [4];
    idli_pkg::op_t cmp_list [6];
    idli_pkg::reg_t lhs;
    logic [7:0] val;
    alu_list[0] = idli_pkg::OP_ADD;
    alu_list[1] = idli_pkg::OP_SUB;
    alu_list[2] = idli_pkg::OP_AND;
    alu_list[3] = idli_pkg::OP_OR;
    cmp_list[0] = idli_pkg::OP_EQ;
    cmp_list[1] = idli_pkg::OP_NE;
    cmp_list[2] = idli_pkg::OP_LT;
    cmp_list[3] = idli_pkg::OP_LTU;
    cmp_list[4] = idli_pkg::OP_GE;
    cmp_list[5] = idli_pkg::OP_GEU;
    // REG_ZR read through the adder must give zero.
    push_instr(make_enc(idli_pkg::OP_ADD, 4'h1, idli_pkg::REG_ZR, idli_pkg::REG_ZR));
    // Give every register a value, then mix random ALU ops and bubbles.
    for (int r = 1; r < 16; r++) begin
      val = 8'($urandom_range(255, 0));
      push_instr(make_enc(idli_pkg::OP_LDI, idli_pkg::reg_t'(r), val[7:4], val[3:0]));
    end
    for (int i = 0; i < 30; i++) begin
      if ($urandom_range(7, 0) == 0) begin
        push_bubble();
      end
      push_instr(make_enc(alu_list[$urandom_range(3, 0)],
                          idli_pkg::reg_t'($urandom_range(15, 0)),
                          idli_pkg::reg_t'($urandom_range(15, 0)),
                          idli_pkg::reg_t'($urandom_range(15, 0))));
    end
    // Each comparison three times, first on equal operands, shown by OUTP.
    for (int c = 0; c < 6; c++) begin
      for (int i = 0; i < 3; i++) begin
        lhs = idli_pkg::reg_t'($urandom_range(15, 0));
        push_instr(make_enc(cmp_list[c], 4'h0, lhs,
                            (i == 0) ? lhs : idli_pkg::reg_t'($urandom_range(15, 0))));
        push_instr(make_enc(idli_pkg::OP_OUTP, 4'h0, 4'h0,
                            idli_pkg::reg_t'($urandom_range(3, 0))));
      end
    end
    // P is one, window 0x08 skips three and the fourth runs.
    push_instr(make_enc(idli_pkg::OP_EQ, 4'h0, idli_pkg::REG_ZR, idli_pkg::REG_ZR));
    push_instr(make_enc(idli_pkg::OP_COND, 4'h0, 4'h0, 4'h8));
    push_instr(make_enc(idli_pkg::OP_LDI, 4'h2, 4'h5, 4'h5));
    push_instr(make_enc(idli_pkg::OP_OUTP, 4'h0, 4'h0, 4'h1));
    push_instr(make_enc(idli_pkg::OP_ADD, 4'h3, 4'h1, 4'h2));
    push_instr(make_enc(idli_pkg::OP_LDI, 4'h4, 4'ha, 4'ha));
    // Random windows after random comparisons, with random code inside.
    for (int i = 0; i < 8; i++) begin
      push_instr(make_enc(cmp_list[$urandom_range(5, 0)], 4'h0,
                          idli_pkg::reg_t'($urandom_range(15, 0)),
                          idli_pkg::reg_t'($urandom_range(15, 0))));
      val = 8'($urandom_range(255, 2));
      push_instr(make_enc(idli_pkg::OP_COND, 4'h0, val[7:4], val[3:0]));
      for (int j = 0; j < 6; j++) begin
        if ($urandom_range(7, 0) == 0) begin
          push_bubble();
        end
        push_instr(random_enc());
      end
    end
    // IN, OUT and OUTN on random pins and registers.
    for (int i = 0; i < 12; i++) begin
      push_instr(make_enc(idli_pkg::OP_IN, idli_pkg::reg_t'($urandom_range(15, 1)),
                          4'h0, idli_pkg::reg_t'($urandom_range(3, 0))));
      push_instr(make_enc((i % 2 == 0) ? idli_pkg::OP_OUT : idli_pkg::OP_OUTN, 4'h0,
                          idli_pkg::reg_t'($urandom_range(15, 0)),
                          idli_pkg::reg_t'($urandom_range(3, 0))));
    end
  endtask

  // Run one instruction through the model and set what its four cycles show.
  task automatic model_step(input idli_pkg::data_t enc, input logic vld,
                            input idli_pkg::io_pins_t pins);
    idli_pkg::op_t      op;
    idli_pkg::data_t    a;
    idli_pkg::data_t    b;
    idli_pkg::pin_idx_t idx;
    logic               taken;
    logic               load_win;
    op       = idli_pkg::op_t'(enc[15:12]);
    a        = model_regs[enc[7:4]];
    b        = model_regs[enc[3:0]];
    idx      = enc[1:0];
    load_win = 1'b0;
    exp_wr   = 1'b0;
    exp_reg  = enc[11:8];
    exp_data = '0;
    exp_pins_before = model_pins;
    taken = vld && !((|model_win[7:1]) && model_pred != model_win[0]);
    if (taken) begin
      case (op)
        idli_pkg::OP_ADD: begin
          exp_wr   = 1'b1;
          exp_data = a + b;
        end
        idli_pkg::OP_SUB: begin
          exp_wr   = 1'b1;
          exp_data = a - b;
        end
        idli_pkg::OP_AND: begin
          exp_wr   = 1'b1;
          exp_data = a & b;
        end
        idli_pkg::OP_OR: begin
          exp_wr   = 1'b1;
          exp_data = a | b;
        end
        idli_pkg::OP_LDI: begin
          exp_wr   = 1'b1;
          exp_data = {8'h00, enc[7:0]};
        end
        idli_pkg::OP_IN: begin
          exp_wr   = 1'b1;
          exp_data = {15'h0000, pins[idx]};
        end
        idli_pkg::OP_EQ:   model_pred = a == b;
        idli_pkg::OP_NE:   model_pred = a != b;
        idli_pkg::OP_LT:   model_pred = $signed(a) < $signed(b);
        idli_pkg::OP_GE:   model_pred = $signed(a) >= $signed(b);
        idli_pkg::OP_LTU:  model_pred = a < b;
        idli_pkg::OP_GEU:  model_pred = a >= b;
        idli_pkg::OP_COND: load_win = 1'b1;
        idli_pkg::OP_OUT:  model_pins[idx] = a[0];
        idli_pkg::OP_OUTN: model_pins[idx] = !a[0];
        idli_pkg::OP_OUTP: model_pins[idx] = model_pred;
        default: ;
      endcase
    end
    // Register zero keeps reading zero even when written.
    if (exp_wr && exp_reg != idli_pkg::REG_ZR) begin
      model_regs[exp_reg] = exp_data;
    end
    // Bubbles leave the window alone; every real instruction moves it.
    if (vld) begin
      model_win = load_win ? enc[7:0] : {1'b0, model_win[7:1]};
    end
    exp_pins_after = model_pins;
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] time=%0t signal=%s expected=0x%0h actual=0x%0h",
               $time, name, exp, got);
    end
  endtask

  // Check one cycle of the instruction in flight; k is the counter value.
  task automatic sample_cycle(input int k);
    check_value("o_ex_wr", 16'(ex_wr), 16'(exp_wr));
    if (exp_wr) begin
      check_value("o_ex_wr_reg", 16'(ex_wr_reg), 16'(exp_reg));
      got_data[k*4 +: 4] = ex_data;
    end
    // The pin update lands on the counter-0 edge.
    if (k == 0) begin
      check_value("o_ex_io_pins", 16'(ex_pins_out), 16'(exp_pins_before));
    end else begin
      check_value("o_ex_io_pins", 16'(ex_pins_out), 16'(exp_pins_after));
    end
    if (k == 3 && exp_wr) begin
      check_value("o_ex_data", got_data, exp_data);
    end
  endtask

  initial begin
    ex_ctr     = '0;
    ex_enc     = '0;
    ex_enc_vld = 1'b0;
    ex_pins_in = '0;
    checks     = 0;
    errors     = 0;
    limit      = 0;
    void'($urandom(12));
    for (int r = 0; r < 16; r++) begin
      model_regs[r] = '0;
    end
    model_pred      = 1'b0;
    model_win       = '0;
    model_pins      = '0;
    exp_wr          = 1'b0;
    exp_reg         = '0;
    exp_data        = '0;
    exp_pins_before = '0;
    exp_pins_after  = '0;
    got_data        = '0;
    build_program();
    limit = 2 * prog_enc.size() * 4 + 20;

    wait (rst_n == 1'b1);
    #10;
    check_value("o_ex_io_pins", 16'(ex_pins_out), 16'h0000);
    check_value("o_ex_wr", 16'(ex_wr), 16'h0000);

    // Slot s runs the instruction presented in slot s-1 and presents
    // instruction s at counter 3. The extra slot drains the last one.
    for (int s = 0; s <= prog_enc.size(); s++) begin
      for (int k = 0; k < 4; k++) begin
        @(negedge gck);
        ex_ctr = idli_pkg::ctr_t'(k);
        if (k == 3) begin
          if (s < prog_enc.size()) begin
            ex_enc     = prog_enc[s];
            ex_enc_vld = prog_vld[s];
            ex_pins_in = prog_pins[s];
          end else begin
            ex_enc_vld = 1'b0;
          end
        end
        // Outputs are settled well before the next rising edge.
        #40;
        sample_cycle(k);
      end
      if (s < prog_enc.size()) begin
        model_step(prog_enc[s], prog_vld[s], prog_pins[s]);
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // The limit is twice the program length in cycles, plus margin for reset.
  always @(posedge gck) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the program did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

endmodule

//--- vlog.f
hdl/idli_pkg.sv
hdl/idli_alu_m.sv
hdl/idli_cond_m.sv
hdl/idli_decode_m.sv
hdl/idli_pins_m.sv
hdl/idli_rf_m.sv
hdl/idli_ex_m.sv
dv/idli_clk_gen.sv
dv/idli_ex_props.sv
dv/idli_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and decide pass or fail from the log.
rm -f sim.log \
  && verilator --binary --timing --assert --top-module idli_tb -f vlog.f -o idli_sim \
  && { ./obj_dir/idli_sim 2>&1 | tee sim.log; } \
  && grep -qx "Test passed" sim.log \
  || { echo "run.sh: pass message not found in sim.log"; exit 1; }
